//--- hdl/rocache_pkg.sv
// --------------------------------------------------
// Read-only cache shared definitions
// Fixed widths, routing choice and the packed
// request, lookup, memory and response structs
// --------------------------------------------------
package rocache_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;

  // Where a decoded read is served from
  typedef enum logic {
    ROUTE_BYPASS = 1'b0,
    ROUTE_CACHE  = 1'b1
  } route_e;

  // Core side
  typedef struct packed {
    addr_t addr;
  } cache_req_t;

  typedef struct packed {
    word_t data;
    logic  error;
  } cache_rsp_t;

  // Between the internal stages
  typedef struct packed {
    addr_t  addr;
    route_e route;
  } dec_req_t;

  typedef struct packed {
    addr_t  addr;
    route_e route;
    logic   hit;
    word_t  data;
  } look_t;

  // Memory side, beats counts the words to return
  typedef struct packed {
    addr_t      addr;
    logic [7:0] beats;
  } mem_req_t;

  typedef struct packed {
    word_t data;
    logic  error;
    logic  last;
  } mem_rsp_t;

endpackage

//--- hdl/rocache_route_decode.sv
// --------------------------------------------------
// Request routing for the read-only cache
// Matches reads against the cacheable rules and
// keeps track of the single request in flight
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_route_decode #(
  parameter int unsigned NrAddrRules = 1
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   enable_i,
  input  rocache_pkg::addr_t [NrAddrRules-1:0]   start_addr_i,
  input  rocache_pkg::addr_t [NrAddrRules-1:0]   end_addr_i,
  input  rocache_pkg::cache_req_t                req_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  logic                                   flush_valid_i,
  output logic                                   flush_ready_o,
  input  logic                                   done_i,
  output rocache_pkg::dec_req_t                  dec_o,
  output logic                                   dec_valid_o,
  output logic                                   flush_o
);

  import rocache_pkg::*;

  logic     busy_q;
  logic     launch_q;
  logic     dec_valid_q;
  logic     rule_hit;
  logic     req_fire;
  route_e   route;
  dec_req_t dec_q;

  // Any rule with start <= addr < end makes the read cacheable
  always_comb begin
    rule_hit = 1'b0;
    for (int unsigned i = 0; i < NrAddrRules; i++) begin
      if (req_i.addr >= start_addr_i[i] && req_i.addr < end_addr_i[i]) begin
        rule_hit = 1'b1;
      end
    end
  end

  assign route = (enable_i && rule_hit) ? ROUTE_CACHE : ROUTE_BYPASS;

  // Flush only while no read is in flight
  assign req_ready_o   = !busy_q;
  assign flush_ready_o = !busy_q;
  assign req_fire      = req_valid_i && req_ready_o;
  assign flush_o       = flush_valid_i && flush_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q      <= 1'b0;
      launch_q    <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      // Lookup starts one edge after the request is captured
      launch_q    <= req_fire;
      dec_valid_q <= launch_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      dec_q <= '{addr: req_i.addr, route: route};
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = dec_valid_q;

endmodule

//--- hdl/rocache_lookup.sv
// --------------------------------------------------
// Direct-mapped line store
// Valid bits, tags and data words with hit check,
// line fill from the miss handler and flush
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_lookup #(
  parameter int unsigned LineWords = 4,
  parameter int unsigned LineCount = 8
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  rocache_pkg::dec_req_t                 dec_i,
  input  logic                                  dec_valid_i,
  input  logic                                  flush_i,
  input  rocache_pkg::addr_t                    fill_addr_i,
  input  rocache_pkg::word_t [LineWords-1:0]    fill_line_i,
  input  logic                                  fill_valid_i,
  output rocache_pkg::look_t                    look_o,
  output logic                                  look_valid_o
);

  import rocache_pkg::*;

  // --------------------------------------------------
  // Address split
  // --------------------------------------------------
  localparam int unsigned ByteBits   = $clog2(DATA_WIDTH / 8);
  localparam int unsigned OffsetBits = $clog2(LineWords);
  localparam int unsigned IndexBits  = $clog2(LineCount);
  localparam int unsigned TagLsb     = ByteBits + OffsetBits + IndexBits;
  localparam int unsigned TagBits    = ADDR_WIDTH - TagLsb;

  typedef logic [TagBits-1:0] tag_t;

  logic [OffsetBits-1:0] look_off;
  logic [IndexBits-1:0]  look_idx;
  tag_t                  look_tag;
  logic [IndexBits-1:0]  fill_idx;
  tag_t                  fill_tag;

  assign look_off = dec_i.addr[ByteBits +: OffsetBits];
  assign look_idx = dec_i.addr[ByteBits + OffsetBits +: IndexBits];
  assign look_tag = dec_i.addr[TagLsb +: TagBits];
  assign fill_idx = fill_addr_i[ByteBits + OffsetBits +: IndexBits];
  assign fill_tag = fill_addr_i[TagLsb +: TagBits];

  // --------------------------------------------------
  // Line store
  // --------------------------------------------------
  logic [LineCount-1:0]  valid_q;
  tag_t                  tag_q  [LineCount];
  word_t [LineWords-1:0] data_q [LineCount];

  // Flush clears every line at once
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_q[fill_idx]  <= fill_tag;
      data_q[fill_idx] <= fill_line_i;
    end
  end

  // --------------------------------------------------
  // Hit check
  // --------------------------------------------------
  logic line_hit;

  // Bypass reads never hit, even if the line is present
  assign line_hit = (dec_i.route == ROUTE_CACHE) && valid_q[look_idx] &&
                    (tag_q[look_idx] == look_tag);

  always_comb begin
    look_o.addr  = dec_i.addr;
    look_o.route = dec_i.route;
    look_o.hit   = line_hit;
    look_o.data  = data_q[look_idx][look_off];
  end

  assign look_valid_o = dec_valid_i;

endmodule

//--- hdl/rocache_miss_handler.sv
// --------------------------------------------------
// Miss handler and response stage
// Fetches lines for misses and single words for
// bypass reads, fills the store and answers the core
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_miss_handler #(
  parameter int unsigned LineWords = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  rocache_pkg::look_t                    look_i,
  input  logic                                  look_valid_i,
  output rocache_pkg::mem_req_t                 mem_req_o,
  output logic                                  mem_req_valid_o,
  input  logic                                  mem_req_ready_i,
  input  rocache_pkg::mem_rsp_t                 mem_rsp_i,
  input  logic                                  mem_rsp_valid_i,
  output logic                                  mem_rsp_ready_o,
  output rocache_pkg::addr_t                    fill_addr_o,
  output rocache_pkg::word_t [LineWords-1:0]    fill_line_o,
  output logic                                  fill_valid_o,
  output rocache_pkg::cache_rsp_t               rsp_o,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output logic                                  done_o
);

  import rocache_pkg::*;

  localparam int unsigned ByteBits   = $clog2(DATA_WIDTH / 8);
  localparam int unsigned OffsetBits = $clog2(LineWords);
  localparam addr_t       LineMask   = addr_t'(LineWords * DATA_WIDTH / 8 - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_COLLECT,
    ST_RESP
  } state_e;

  state_e                state_q;
  logic                  fill_valid_q;
  addr_t                 addr_q;
  route_e                route_q;
  mem_req_t              mem_req_q;
  logic [OffsetBits-1:0] beat_q;
  logic                  err_q;
  word_t [LineWords-1:0] line_q;
  word_t [LineWords-1:0] line_d;
  cache_rsp_t            rsp_q;

  logic                  beat_fire;
  logic                  beat_err;
  logic [OffsetBits-1:0] word_off;

  assign beat_fire = mem_rsp_valid_i && mem_rsp_ready_o;
  assign beat_err  = err_q || mem_rsp_i.error;
  assign word_off  = addr_q[ByteBits +: OffsetBits];

  // Line buffer including the beat arriving now
  always_comb begin
    line_d         = line_q;
    line_d[beat_q] = mem_rsp_i.data;
  end

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= ST_IDLE;
      fill_valid_q <= 1'b0;
    end else begin
      fill_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (look_valid_i) begin
            state_q <= look_i.hit ? ST_RESP : ST_REQ;
          end
        end
        ST_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= ST_COLLECT;
          end
        end
        ST_COLLECT: begin
          if (beat_fire && mem_rsp_i.last) begin
            state_q <= ST_RESP;
            // Lines with a failing beat stay out of the store
            fill_valid_q <= (route_q == ROUTE_CACHE) && !beat_err;
          end
        end
        ST_RESP: begin
          if (rsp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Request, line and response registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && look_valid_i) begin
      addr_q  <= look_i.addr;
      route_q <= look_i.route;
      beat_q  <= '0;
      err_q   <= 1'b0;
      rsp_q   <= '{data: look_i.data, error: 1'b0};
      if (look_i.route == ROUTE_CACHE) begin
        mem_req_q <= '{addr: look_i.addr & ~LineMask, beats: 8'(LineWords)};
      end else begin
        mem_req_q <= '{addr: look_i.addr, beats: 8'd1};
      end
    end else if (beat_fire) begin
      line_q <= line_d;
      beat_q <= beat_q + 1'b1;
      err_q  <= beat_err;
      if (mem_rsp_i.last) begin
        rsp_q.data  <= (route_q == ROUTE_CACHE) ? line_d[word_off] : mem_rsp_i.data;
        rsp_q.error <= beat_err;
      end
    end
  end

  assign mem_req_o       = mem_req_q;
  assign mem_req_valid_o = (state_q == ST_REQ);
  assign mem_rsp_ready_o = (state_q == ST_COLLECT);

  assign fill_addr_o  = mem_req_q.addr;
  assign fill_line_o  = line_q;
  assign fill_valid_o = fill_valid_q;

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = (state_q == ST_RESP);
  assign done_o      = rsp_valid_o && rsp_ready_i;

endmodule

//--- hdl/rocache_top.sv
// --------------------------------------------------
// Read-only cache top level
// Routes core reads to a direct-mapped store or
// straight to memory, one request in flight
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_top #(
  parameter int unsigned LineWords   = 4,
  parameter int unsigned LineCount   = 8,
  parameter int unsigned NrAddrRules = 2
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   enable_i,
  input  rocache_pkg::addr_t [NrAddrRules-1:0]   start_addr_i,
  input  rocache_pkg::addr_t [NrAddrRules-1:0]   end_addr_i,
  input  logic                                   flush_valid_i,
  output logic                                   flush_ready_o,
  // Core side
  input  rocache_pkg::cache_req_t                req_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  output rocache_pkg::cache_rsp_t                rsp_o,
  output logic                                   rsp_valid_o,
  input  logic                                   rsp_ready_i,
  // Memory side
  output rocache_pkg::mem_req_t                  mem_req_o,
  output logic                                   mem_req_valid_o,
  input  logic                                   mem_req_ready_i,
  input  rocache_pkg::mem_rsp_t                  mem_rsp_i,
  input  logic                                   mem_rsp_valid_i,
  output logic                                   mem_rsp_ready_o
);

  import rocache_pkg::*;

  dec_req_t              dec;
  logic                  dec_valid;
  logic                  flush;
  look_t                 look;
  logic                  look_valid;
  addr_t                 fill_addr;
  word_t [LineWords-1:0] fill_line;
  logic                  fill_valid;
  logic                  done;

  rocache_route_decode #(
    .NrAddrRules ( NrAddrRules )
  ) route_decode_inst (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .enable_i      ( enable_i      ),
    .start_addr_i  ( start_addr_i  ),
    .end_addr_i    ( end_addr_i    ),
    .req_i         ( req_i         ),
    .req_valid_i   ( req_valid_i   ),
    .req_ready_o   ( req_ready_o   ),
    .flush_valid_i ( flush_valid_i ),
    .flush_ready_o ( flush_ready_o ),
    .done_i        ( done          ),
    .dec_o         ( dec           ),
    .dec_valid_o   ( dec_valid     ),
    .flush_o       ( flush         )
  );

  rocache_lookup #(
    .LineWords ( LineWords ),
    .LineCount ( LineCount )
  ) lookup_inst (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .dec_i        ( dec        ),
    .dec_valid_i  ( dec_valid  ),
    .flush_i      ( flush      ),
    .fill_addr_i  ( fill_addr  ),
    .fill_line_i  ( fill_line  ),
    .fill_valid_i ( fill_valid ),
    .look_o       ( look       ),
    .look_valid_o ( look_valid )
  );

  rocache_miss_handler #(
    .LineWords ( LineWords )
  ) miss_handler_inst (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .look_i          ( look            ),
    .look_valid_i    ( look_valid      ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_ready_o ( mem_rsp_ready_o ),
    .fill_addr_o     ( fill_addr       ),
    .fill_line_o     ( fill_line       ),
    .fill_valid_o    ( fill_valid      ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .done_o          ( done            )
  );

endmodule

//--- test/rocache_asserts.sv
// --------------------------------------------------
// Handshake checks for the read-only cache
// Bound to the top level from the testbench
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_asserts (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    req_valid_i,
  input logic                    req_ready_o,
  input rocache_pkg::cache_rsp_t rsp_o,
  input logic                    rsp_valid_o,
  input logic                    rsp_ready_i,
  input rocache_pkg::mem_req_t   mem_req_o,
  input logic                    mem_req_valid_o,
  input logic                    mem_req_ready_i
);

  // Number of failed properties so far
  int unsigned fail_count = 0;

  // Stalled response keeps valid and payload
  rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
      fail_count++;
      $error("rsp_o changed or dropped while the core stalled");
    end

  // Same for a memory request that is not yet taken
  mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else begin
      fail_count++;
      $error("mem_req_o changed or dropped while memory stalled");
    end

  // One read in flight
  req_block: assert property (@(posedge clk_i) disable iff (reset_i)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else begin
      fail_count++;
      $error("req_ready_o stayed high after a request was accepted");
    end

  req_wait: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_ready_o && !(rsp_valid_o && rsp_ready_i) |=> !req_ready_o)
    else begin
      fail_count++;
      $error("req_ready_o rose before the response was taken");
    end

endmodule

//--- test/rocache_tb.sv
// --------------------------------------------------
// Read-only cache testbench
// Random reads against a memory model and a
// reference cache model, with flush and back-pressure
// --------------------------------------------------
`timescale 1ns/1ps

module rocache_tb;

  import rocache_pkg::*;

  localparam int unsigned LINE_WORDS     = 4;
  localparam int unsigned LINE_COUNT     = 8;
  localparam int unsigned NUM_RULES      = 2;
  localparam int unsigned NUM_RANDOM     = 240;
  localparam int unsigned NUM_DIRECTED   = 40;
  // Refill with slow memory and a stalled core stays well below this
  localparam int unsigned CYCLES_PER_REQ = 80;
  localparam int unsigned TIMEOUT_CYCLES =
    (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_REQ + 500;
  localparam addr_t ERR_LO   = 32'h0000_2080;
  localparam addr_t ERR_HI   = 32'h0000_20a0;
  localparam word_t GEN_MULT = 32'h9e37_79b9;

  logic                  clk_i;
  logic                  reset_i;
  logic                  enable_i;
  addr_t [NUM_RULES-1:0] start_addr_i;
  addr_t [NUM_RULES-1:0] end_addr_i;
  logic                  flush_valid_i;
  logic                  flush_ready_o;
  cache_req_t            req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  cache_rsp_t            rsp_o;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  mem_req_t              mem_req_o;
  logic                  mem_req_valid_o;
  logic                  mem_req_ready_i = 1'b0;
  mem_rsp_t              mem_rsp_i       = '0;
  logic                  mem_rsp_valid_i = 1'b0;
  logic                  mem_rsp_ready_o;

  integer      seed;
  int unsigned cycle     = 0;
  int unsigned errors;
  int unsigned checks;
  int unsigned gen;
  logic        en;

  // Memory model state
  logic        mem_busy  = 1'b0;
  addr_t       beat_addr;
  logic [7:0]  beats_left;
  int unsigned mem_count = 0;
  mem_req_t    last_mem_req;

  // Reference cache, index addr[6:4] and tag addr[31:7]
  logic        model_valid [LINE_COUNT];
  logic [24:0] model_tag   [LINE_COUNT];
  int unsigned model_gen   [LINE_COUNT];

  rocache_top #(
    .LineWords   ( LINE_WORDS ),
    .LineCount   ( LINE_COUNT ),
    .NrAddrRules ( NUM_RULES  )
  ) rocache_top_inst (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .enable_i        ( enable_i        ),
    .start_addr_i    ( start_addr_i    ),
    .end_addr_i      ( end_addr_i      ),
    .flush_valid_i   ( flush_valid_i   ),
    .flush_ready_o   ( flush_ready_o   ),
    .req_i           ( req_i           ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_ready_o ( mem_rsp_ready_o )
  );

  bind rocache_top rocache_asserts asserts_inst (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i )
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a read or flush never completed", cycle);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Model helpers
  // --------------------------------------------------
  function automatic word_t mem_word(input addr_t addr, input int unsigned g);
    return word_t'(addr >> 2) ^ (word_t'(g) * GEN_MULT);
  endfunction

  function automatic logic in_err_window(input addr_t addr);
    return (addr >= ERR_LO) && (addr < ERR_HI);
  endfunction

  function automatic logic is_cacheable(input addr_t addr);
    logic found;
    found = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (addr >= start_addr_i[i] && addr < end_addr_i[i]) begin
        found = 1'b1;
      end
    end
    return en && found;
  endfunction

  // Small windows so that lines alias and hit often
  function automatic addr_t random_addr();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0, 2'd1: return 32'h0000_1000 + {24'h0, r[9:4], 2'b00};
      2'd2:       return 32'h0000_2000 + {24'h0, r[9:4], 2'b00};
      default:    return 32'h0000_3000 + {24'h0, r[9:4], 2'b00};
    endcase
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // --------------------------------------------------
  // Memory model
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_busy        <= 1'b0;
      mem_req_ready_i <= 1'b0;
      mem_rsp_valid_i <= 1'b0;
    end else if (!mem_busy) begin
      if (mem_req_valid_o && mem_req_ready_i) begin
        mem_busy        <= 1'b1;
        mem_req_ready_i <= 1'b0;
        beat_addr       <= mem_req_o.addr;
        beats_left      <= mem_req_o.beats;
        last_mem_req    <= mem_req_o;
        mem_count       <= mem_count + 1;
      end else begin
        mem_req_ready_i <= 1'($random(seed));
      end
    end else if (mem_rsp_valid_i && mem_rsp_ready_o) begin
      mem_rsp_valid_i <= 1'b0;
      beat_addr       <= beat_addr + 32'd4;
      beats_left      <= beats_left - 8'd1;
      if (mem_rsp_i.last) begin
        mem_busy <= 1'b0;
      end
    end else if (!mem_rsp_valid_i && (($random(seed) & 3) != 0)) begin
      mem_rsp_valid_i <= 1'b1;
      mem_rsp_i       <= '{data:  mem_word(beat_addr, gen),
                           error: in_err_window(beat_addr),
                           last:  beats_left == 8'd1};
    end
  end

  // Beats are taken only while the model still owes some
  always @(posedge clk_i) begin
    if (!reset_i) begin
      check_equal("mem_rsp_ready", 64'(mem_busy), 64'(mem_rsp_ready_o));
    end
  end

  // --------------------------------------------------
  // Core side tasks
  // --------------------------------------------------
  task automatic set_enable(input logic value);
    en = value;
    enable_i <= value;
  endtask

  task automatic do_flush();
    flush_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!flush_ready_o) @(posedge clk_i);
    flush_valid_i <= 1'b0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      model_valid[i] = 1'b0;
    end
  endtask

  task automatic do_read(input string name, input addr_t addr);
    logic        cached;
    logic        hit;
    logic        exp_err;
    logic        seen;
    logic        done;
    int unsigned idx;
    int unsigned exp_gen;
    int unsigned mem_before;
    int unsigned acc_cycle;
    int unsigned rsp_cycle;
    cache_rsp_t  got;
    mem_req_t    exp_req;

    // Prediction
    idx     = 32'(addr[6:4]);
    cached  = is_cacheable(addr);
    hit     = cached && model_valid[idx] && (model_tag[idx] == addr[31:7]);
    exp_gen = hit ? model_gen[idx] : gen;
    exp_err = 1'b0;
    if (cached) begin
      exp_req = '{addr: addr & ~32'hf, beats: 8'(LINE_WORDS)};
      for (int w = 0; w < LINE_WORDS; w++) begin
        exp_err = exp_err | in_err_window(exp_req.addr + addr_t'(4 * w));
      end
    end else begin
      exp_req = '{addr: addr, beats: 8'd1};
      exp_err = in_err_window(addr);
    end
    if (hit) begin
      exp_err = 1'b0;
    end

    mem_before  = mem_count;
    req_i       <= '{addr: addr};
    req_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    acc_cycle   = cycle;
    req_valid_i <= 1'b0;
    // The previous response must not show up again
    check_equal({name, " rsp_valid at accept"}, 64'd0, 64'(rsp_valid_o));

    // Response with random back-pressure
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      rsp_ready_i <= 1'(($random(seed) & 3) != 0);
      @(posedge clk_i);
      if (rsp_valid_o && !seen) begin
        seen      = 1'b1;
        rsp_cycle = cycle;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        done = 1'b1;
        got  = rsp_o;
      end else begin
        check_equal({name, " busy"}, 64'd0, 64'(req_ready_o));
      end
    end

    // Error-free misses fill the line
    if (cached && !hit && !exp_err) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = addr[31:7];
      model_gen[idx]   = gen;
    end

    check_equal({name, " data"}, 64'(mem_word(addr, exp_gen)), 64'(got.data));
    check_equal({name, " error"}, 64'(exp_err), 64'(got.error));
    if (hit) begin
      // Seen one edge after it rises
      check_equal({name, " hit latency"}, 64'd2, 64'(rsp_cycle - acc_cycle - 1));
      check_equal({name, " hit mem reqs"}, 64'd0, 64'(mem_count - mem_before));
    end else begin
      check_equal({name, " mem reqs"}, 64'd1, 64'(mem_count - mem_before));
      check_equal({name, " mem req"}, 64'(exp_req), 64'(last_mem_req));
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] r;

    seed            = 32'h2e93_4a3c;
    errors          = 0;
    checks          = 0;
    gen             = 1;
    en              = 1'b1;
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    enable_i        = 1'b1;
    start_addr_i[0] = 32'h0000_1000;
    end_addr_i[0]   = 32'h0000_1400;
    start_addr_i[1] = 32'h0000_2000;
    end_addr_i[1]   = 32'h0000_2100;
    flush_valid_i   = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    rsp_ready_i     = 1'b0;
    for (int i = 0; i < LINE_COUNT; i++) begin
      model_valid[i] = 1'b0;
    end

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_equal("reset req_ready", 64'd1, 64'(req_ready_o));
    check_equal("reset flush_ready", 64'd1, 64'(flush_ready_o));
    check_equal("reset rsp_valid", 64'd0, 64'(rsp_valid_o));
    check_equal("reset mem_req_valid", 64'd0, 64'(mem_req_valid_o));

    // Fill then hit, and the rule boundary
    do_read("fill", 32'h0000_1044);
    do_read("hit", 32'h0000_1048);
    do_read("hit again", 32'h0000_1044);
    do_read("rule last word", 32'h0000_13fc);
    do_read("rule end", 32'h0000_1400);

    // Stale lines survive a generation bump until a flush
    for (int i = 0; i < 4; i++) begin
      do_read("warm", 32'h0000_1000 + addr_t'(16 * i));
    end
    gen++;
    for (int i = 0; i < 4; i++) begin
      do_read("stale", 32'h0000_1000 + addr_t'(16 * i));
    end
    do_flush();
    for (int i = 0; i < 4; i++) begin
      do_read("refetch", 32'h0000_1000 + addr_t'(16 * i));
    end

    // Bypass reads
    set_enable(1'b0);
    for (int i = 0; i < 4; i++) begin
      do_read("disabled", 32'h0000_1004 + addr_t'(16 * i));
    end
    set_enable(1'b1);
    do_read("outside", 32'h0000_3010);
    do_read("outside again", 32'h0000_3010);

    // Error lines never enter the store
    do_read("error", 32'h0000_2084);
    do_read("error again", 32'h0000_2084);
    do_read("error line", 32'h0000_2088);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      if (r[4:0] == 5'd0) begin
        do_flush();
      end
      if (r[9:5] == 5'd0) begin
        gen++;
      end
      if (r[14:10] == 5'd0) begin
        set_enable(!en);
      end
      do_read("random", random_addr());
    end

    errors += rocache_top_inst.asserts_inst.fail_count;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- rocache.f
hdl/rocache_pkg.sv
hdl/rocache_route_decode.sv
hdl/rocache_lookup.sv
hdl/rocache_miss_handler.sv
hdl/rocache_top.sv
test/rocache_asserts.sv
test/rocache_tb.sv

//--- run.sh
#!/bin/sh
# Builds the read-only cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f rocache.f \
  --top-module rocache_tb -o rocache_sim
status=0
./obj_dir/rocache_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
